// File: common/tart_consts.svh
`ifndef TART_CONSTS_SVH
`define TART_CONSTS_SVH

// ----------------------------------------
// Correlator sizing
// ----------------------------------------
`define TART_ANTENNAE   4      // 1-bit antenna inputs
`define TART_PAIRS      6      // All unordered antenna pairs
`define TART_ACC_BITS   8      // Agreement counter and visibility width

// ----------------------------------------
// Bus sizing
// ----------------------------------------
`define TART_BUS_BITS   8      // Wishbone data
`define TART_ADR_BITS   7      // Wishbone address
`define TART_LOG2_BITS  3      // Block-size exponent, blocks of 2^n samples

// Address-block codes
// Control unit matches adr[6:3], visibilities unit matches adr[6:4]
`define TART_CTRL_BLOCK 4'hF
`define TART_VIS_BLOCK  3'h0

`endif

// File: common/tart_bus_pkg.sv
package tart_bus_pkg;

   // ----------------------------------------
   // Wishbone slave handshake
   // ----------------------------------------
   typedef enum logic {
      DEC_IDLE,   // Waiting for a strobe
      DEC_ACK     // Acknowledge cycle, strobe not resampled
   } dec_state_t;

   // Decoded access, held until acknowledge
   typedef enum logic [2:0] {
      OP_NONE,       // Idle or ignored write
      OP_REG_RD,     // Control unit read
      OP_REG_WR,     // Control unit write
      OP_VIS_RD,     // Visibilities read-back
      OP_UNMAPPED    // Acked, reads as zero
   } bus_op_t;

   // ----------------------------------------
   // Control unit register map, adr[1:0]
   // ----------------------------------------
   typedef enum logic [1:0] {
      REG_CTRL     = 2'd0,  // [0] enable, [7] soft reset (self-clearing)
      REG_BLOCK    = 2'd1,  // [2:0] block-size exponent
      REG_STATUS   = 2'd2,  // [0] available, [1] overflow, [2] enabled
      REG_CHECKSUM = 2'd3   // Sum of last bank, mod 256
   } reg_idx_t;

endpackage

// File: common/tart_corr_pkg.sv
`include "tart_consts.svh"

package tart_corr_pkg;

   // ----------------------------------------
   // Correlator data types
   // ----------------------------------------
   typedef logic [`TART_ACC_BITS-1:0] vis_t;   // One agreement count
   typedef logic [2:0]                pair_idx_t;
   typedef logic [1:0]                ant_idx_t;

   // Pair order used by counters and read-back
   //   0:(0,1) 1:(0,2) 2:(0,3) 3:(1,2) 4:(1,3) 5:(2,3)
   // Packed, so element 0 is the rightmost entry
   localparam ant_idx_t [`TART_PAIRS-1:0] pair_a = {
      2'd2, 2'd1, 2'd1, 2'd0, 2'd0, 2'd0
   };
   localparam ant_idx_t [`TART_PAIRS-1:0] pair_b = {
      2'd3, 2'd3, 2'd2, 2'd3, 2'd2, 2'd1
   };

   // Reading this index releases the bank
   localparam pair_idx_t last_pair = 3'(`TART_PAIRS - 1);

endpackage

// File: bus/wb_decoder.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module wb_decoder (
   input  logic                        b_clk,
   input  logic                        rst_n_i,
   // Wishbone classic slave
   input  logic                        cyc_i,
   input  logic                        stb_i,
   input  logic                        we_i,
   input  logic [`TART_ADR_BITS-1:0]   adr_i,
   input  logic [`TART_BUS_BITS-1:0]   dat_i,
   output logic [`TART_BUS_BITS-1:0]   dat_o,
   output logic                        ack_o,
   // Control unit
   output logic                        reg_wr_o,
   output tart_bus_pkg::reg_idx_t      reg_idx_o,
   output logic [`TART_BUS_BITS-1:0]   wr_dat_o,
   input  logic [`TART_BUS_BITS-1:0]   reg_dat_i,
   // Visibilities bank
   output logic                        vis_rd_o,
   output logic [3:0]                  vis_idx_o,
   input  tart_corr_pkg::vis_t         vis_dat_i
);

   tart_bus_pkg::dec_state_t    state_q;
   tart_bus_pkg::bus_op_t       op_d;
   tart_bus_pkg::bus_op_t       op_q;
   logic                        start;         // New strobe seen in idle
   logic [3:0]                  idx_q;         // Low address bits of the access
   logic [`TART_BUS_BITS-1:0]   dat_q;

   assign start = (state_q == tart_bus_pkg::DEC_IDLE) && cyc_i && stb_i;

   // ----------------------------------------
   // Address block and direction to operation
   // ----------------------------------------
   always_comb begin
      op_d = tart_bus_pkg::OP_UNMAPPED;
      if (adr_i[`TART_ADR_BITS-1 -: 4] == `TART_CTRL_BLOCK) begin
         if (we_i) op_d = tart_bus_pkg::OP_REG_WR;
         else      op_d = tart_bus_pkg::OP_REG_RD;
      end else if (adr_i[`TART_ADR_BITS-1 -: 3] == `TART_VIS_BLOCK) begin
         if (we_i) op_d = tart_bus_pkg::OP_NONE;   // Bank is read-only
         else      op_d = tart_bus_pkg::OP_VIS_RD;
      end
   end

   // Handshake FSM, exactly one ack per strobe
   always_ff @(posedge b_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= tart_bus_pkg::DEC_IDLE;
         op_q    <= tart_bus_pkg::OP_NONE;
      end else if (start) begin
         state_q <= tart_bus_pkg::DEC_ACK;
         op_q    <= op_d;                       // Held through the ack cycle
      end else begin
         state_q <= tart_bus_pkg::DEC_IDLE;     // Skip the still-high strobe
         op_q    <= tart_bus_pkg::OP_NONE;
      end
   end

   always_ff @(posedge b_clk) begin
      if (start) begin
         idx_q <= adr_i[3:0];
         dat_q <= dat_i;
      end
   end

   // ----------------------------------------
   // Outputs, valid during the ack cycle
   // ----------------------------------------
   assign ack_o     = (state_q == tart_bus_pkg::DEC_ACK);
   assign reg_wr_o  = ack_o && (op_q == tart_bus_pkg::OP_REG_WR);
   assign reg_idx_o = tart_bus_pkg::reg_idx_t'(idx_q[1:0]);
   assign wr_dat_o  = dat_q;
   assign vis_rd_o  = ack_o && (op_q == tart_bus_pkg::OP_VIS_RD);   // Bank watches index 5
   assign vis_idx_o = idx_q;

   always_comb begin
      case (op_q)
         tart_bus_pkg::OP_REG_RD: dat_o = reg_dat_i;
         tart_bus_pkg::OP_VIS_RD: dat_o = vis_dat_i;
         default:                 dat_o = '0;   // Unmapped and writes read zero
      endcase
   end

endmodule

// File: bus/ctrl_regs.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module ctrl_regs (
   input  logic                          b_clk,
   input  logic                          rst_n_i,
   // From the decoder, ack cycle only
   input  logic                          reg_wr_i,
   input  tart_bus_pkg::reg_idx_t        reg_idx_i,
   input  logic [`TART_BUS_BITS-1:0]     wr_dat_i,
   output logic [`TART_BUS_BITS-1:0]     reg_dat_o,
   // Bank status
   input  logic                          available_i,
   input  logic                          overflow_i,
   input  logic [`TART_BUS_BITS-1:0]     checksum_i,
   // Correlator control
   output logic                          enable_o,
   output logic [`TART_LOG2_BITS-1:0]    block_log2_o,
   output logic                          soft_clr_o     // One-cycle pulse
);

   // ----------------------------------------
   // Writable registers
   // ----------------------------------------
   always_ff @(posedge b_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         enable_o     <= 1'b0;
         block_log2_o <= '0;               // Single-sample blocks
         soft_clr_o   <= 1'b0;
      end else begin
         soft_clr_o <= 1'b0;               // Self-clearing
         if (reg_wr_i) begin
            case (reg_idx_i)
               tart_bus_pkg::REG_CTRL: begin
                  enable_o   <= wr_dat_i[0];
                  soft_clr_o <= wr_dat_i[7];
               end
               tart_bus_pkg::REG_BLOCK: block_log2_o <= wr_dat_i[`TART_LOG2_BITS-1:0];
               default: ;                  // Status and checksum are read-only
            endcase
         end
      end
   end

   // Read-back, soft-reset bit always reads 0
   always_comb begin
      case (reg_idx_i)
         tart_bus_pkg::REG_CTRL:
            reg_dat_o = {{(`TART_BUS_BITS-1){1'b0}}, enable_o};
         tart_bus_pkg::REG_BLOCK:
            reg_dat_o = {{(`TART_BUS_BITS-`TART_LOG2_BITS){1'b0}}, block_log2_o};
         tart_bus_pkg::REG_STATUS:
            reg_dat_o = {{(`TART_BUS_BITS-3){1'b0}}, enable_o, overflow_i, available_i};
         default:
            reg_dat_o = checksum_i;
      endcase
   end

endmodule

// File: correlator/corr_accumulate.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module corr_accumulate (
   input  logic                                  b_clk,
   input  logic                                  rst_n_i,
   input  logic [`TART_ANTENNAE-1:0]             antenna_i,
   input  logic                                  antenna_valid_i,
   input  logic                                  enable_i,
   input  logic [`TART_LOG2_BITS-1:0]            block_log2_i,
   input  logic                                  soft_clr_i,
   output logic                                  blk_done_o,   // One cycle per block
   output tart_corr_pkg::vis_t [`TART_PAIRS-1:0] blk_vis_o     // Counts of that block
);

   localparam int CNT_BITS = (1 << `TART_LOG2_BITS) - 1;   // Index within a block

   logic                                  take;          // Sample accepted this cycle
   logic [CNT_BITS-1:0]                   cnt_q;
   logic [`TART_LOG2_BITS-1:0]            log2_q;        // Exponent of current block
   logic [`TART_LOG2_BITS-1:0]            log2_cur;
   logic [CNT_BITS:0]                     end_cnt;
   logic                                  at_end;
   logic                                  s1_vld_q;
   logic                                  s1_last_q;
   logic [`TART_ANTENNAE-1:0]             s1_ant_q;
   logic [`TART_PAIRS-1:0]                agree;
   tart_corr_pkg::vis_t [`TART_PAIRS-1:0] acc_q;
   tart_corr_pkg::vis_t [`TART_PAIRS-1:0] acc_nxt;

   assign take     = antenna_valid_i && enable_i;
   assign log2_cur = (cnt_q == '0) ? block_log2_i : log2_q;   // New size at block start
   assign end_cnt  = ({{CNT_BITS{1'b0}}, 1'b1} << log2_cur) - 1'b1;
   assign at_end   = ({1'b0, cnt_q} == end_cnt);

   // ----------------------------------------
   // Stage 1, sample register and last flag
   // ----------------------------------------
   always_ff @(posedge b_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q     <= '0;
         log2_q    <= '0;
         s1_vld_q  <= 1'b0;
         s1_last_q <= 1'b0;
      end else if (soft_clr_i) begin
         cnt_q     <= '0;
         log2_q    <= '0;
         s1_vld_q  <= 1'b0;
         s1_last_q <= 1'b0;
      end else begin
         s1_vld_q <= take;
         if (take) begin
            s1_last_q <= at_end;
            log2_q    <= log2_cur;
            cnt_q     <= at_end ? '0 : cnt_q + 1'b1;   // Wrap at 2^n
         end
      end
   end

   always_ff @(posedge b_clk) begin
      if (take) s1_ant_q <= antenna_i;
   end

   // Agreement per pair, XNOR of the two bits
   always_comb begin
      for (int p = 0; p < `TART_PAIRS; p++) begin
         agree[p]   = ~(s1_ant_q[tart_corr_pkg::pair_a[p]] ^ s1_ant_q[tart_corr_pkg::pair_b[p]]);
         acc_nxt[p] = acc_q[p] + {{(`TART_ACC_BITS-1){1'b0}}, agree[p]};
      end
   end

   // ----------------------------------------
   // Stage 2, counters
   // ----------------------------------------
   always_ff @(posedge b_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         acc_q      <= '0;
         blk_done_o <= 1'b0;
      end else if (soft_clr_i) begin
         acc_q      <= '0;
         blk_done_o <= 1'b0;
      end else begin
         blk_done_o <= s1_vld_q && s1_last_q;
         if (s1_vld_q) acc_q <= s1_last_q ? '0 : acc_nxt;   // Restart after last
      end
   end

   // Finished counts include the last sample
   always_ff @(posedge b_clk) begin
      if (s1_vld_q && s1_last_q) blk_vis_o <= acc_nxt;
   end

endmodule

// File: correlator/visibility_bank.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module visibility_bank (
   input  logic                                  b_clk,
   input  logic                                  rst_n_i,
   input  logic                                  blk_done_i,
   input  tart_corr_pkg::vis_t [`TART_PAIRS-1:0] blk_vis_i,
   input  logic                                  vis_rd_i,
   input  logic [3:0]                            vis_idx_i,
   input  logic                                  soft_clr_i,
   output tart_corr_pkg::vis_t                   vis_dat_o,
   output logic                                  available_o,  // Unread bank held
   output logic                                  overflow_o,   // Block lost
   output logic [`TART_BUS_BITS-1:0]             checksum_o,
   output logic                                  newblock_o
);

   tart_corr_pkg::vis_t [`TART_PAIRS-1:0] vis_q;
   tart_corr_pkg::pair_idx_t              sel;
   tart_corr_pkg::vis_t                   sum;
   logic                                  load;
   logic                                  idx_ok;
   logic                                  rd_last;

   // Only an empty bank takes a block
   assign load       = blk_done_i && !available_o && !soft_clr_i;
   assign newblock_o = load;

   // ----------------------------------------
   // Read-back mux
   // ----------------------------------------
   assign sel       = vis_idx_i[2:0];
   assign idx_ok    = (vis_idx_i <= {1'b0, tart_corr_pkg::last_pair});
   assign vis_dat_o = idx_ok ? vis_q[sel] : '0;   // Indexes 6..15 read zero
   assign rd_last   = vis_rd_i && (vis_idx_i == {1'b0, tart_corr_pkg::last_pair});

   // Checksum, wraps mod 256
   always_comb begin
      sum = '0;
      for (int p = 0; p < `TART_PAIRS; p++) begin
         sum = sum + blk_vis_i[p];
      end
   end

   // ----------------------------------------
   // Bank and flags
   // ----------------------------------------
   always_ff @(posedge b_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         vis_q       <= '0;
         checksum_o  <= '0;
         available_o <= 1'b0;
         overflow_o  <= 1'b0;
      end else if (soft_clr_i) begin
         available_o <= 1'b0;              // Contents kept, flags dropped
         overflow_o  <= 1'b0;
      end else begin
         if (rd_last) available_o <= 1'b0;
         if (load) begin
            vis_q       <= blk_vis_i;
            checksum_o  <= `TART_BUS_BITS'(sum);
            available_o <= 1'b1;
         end else if (blk_done_i) begin
            overflow_o  <= 1'b1;           // Old contents stay
         end
      end
   end

endmodule

// File: src/tart_core.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module tart_core (
   input  logic                        b_clk,
   input  logic                        rst_n_i,
   // Wishbone classic slave
   input  logic                        cyc_i,
   input  logic                        stb_i,
   input  logic                        we_i,
   input  logic [`TART_ADR_BITS-1:0]   adr_i,
   input  logic [`TART_BUS_BITS-1:0]   dat_i,
   output logic [`TART_BUS_BITS-1:0]   dat_o,
   output logic                        ack_o,
   // Antenna samples
   input  logic [`TART_ANTENNAE-1:0]   antenna_i,
   input  logic                        antenna_valid_i,
   output logic                        newblock_o     // Bank just loaded
);

   // Decoder <-> control unit
   logic                                  reg_wr;
   tart_bus_pkg::reg_idx_t                reg_idx;
   logic [`TART_BUS_BITS-1:0]             wr_dat;
   logic [`TART_BUS_BITS-1:0]             reg_dat;
   // Decoder <-> bank
   logic                                  vis_rd;
   logic [3:0]                            vis_idx;
   tart_corr_pkg::vis_t                   vis_dat;
   // Control and status
   logic                                  enable;
   logic [`TART_LOG2_BITS-1:0]            block_log2;
   logic                                  soft_clr;
   logic                                  available;
   logic                                  overflow;
   logic [`TART_BUS_BITS-1:0]             checksum;
   // Correlator -> bank
   logic                                  blk_done;
   tart_corr_pkg::vis_t [`TART_PAIRS-1:0] blk_vis;

   // ----------------------------------------
   // Bus side
   // ----------------------------------------
   wb_decoder i_wb_decoder (
      .b_clk    (b_clk),     .rst_n_i  (rst_n_i),
      .cyc_i    (cyc_i),     .stb_i    (stb_i),     .we_i     (we_i),
      .adr_i    (adr_i),     .dat_i    (dat_i),     .dat_o    (dat_o),
      .ack_o    (ack_o),
      .reg_wr_o (reg_wr),    .reg_idx_o(reg_idx),   .wr_dat_o (wr_dat),
      .reg_dat_i(reg_dat),
      .vis_rd_o (vis_rd),    .vis_idx_o(vis_idx),   .vis_dat_i(vis_dat)
   );

   ctrl_regs i_ctrl_regs (
      .b_clk      (b_clk),      .rst_n_i     (rst_n_i),
      .reg_wr_i   (reg_wr),     .reg_idx_i   (reg_idx),    .wr_dat_i  (wr_dat),
      .available_i(available),  .overflow_i  (overflow),   .checksum_i(checksum),
      .reg_dat_o  (reg_dat),    .enable_o    (enable),
      .block_log2_o(block_log2), .soft_clr_o (soft_clr)
   );

   // ----------------------------------------
   // Correlator and result bank
   // ----------------------------------------
   corr_accumulate i_corr_accumulate (
      .b_clk          (b_clk),          .rst_n_i     (rst_n_i),
      .antenna_i      (antenna_i),      .antenna_valid_i(antenna_valid_i),
      .enable_i       (enable),         .block_log2_i(block_log2),
      .soft_clr_i     (soft_clr),
      .blk_done_o     (blk_done),       .blk_vis_o   (blk_vis)
   );

   visibility_bank i_visibility_bank (
      .b_clk      (b_clk),      .rst_n_i    (rst_n_i),
      .blk_done_i (blk_done),   .blk_vis_i  (blk_vis),
      .vis_rd_i   (vis_rd),     .vis_idx_i  (vis_idx),    .soft_clr_i(soft_clr),
      .vis_dat_o  (vis_dat),    .available_o(available),  .overflow_o(overflow),
      .checksum_o (checksum),   .newblock_o (newblock_o)
   );

endmodule

// File: bench/tart_assert.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module tart_assert (
   input logic                          b_clk,
   input logic                          rst_n_i,
   input logic                          cyc_i,
   input logic                          stb_i,
   input logic                          ack_i,
   input logic                          antenna_valid_i,
   input logic                          newblock_i,
   input logic                          enable_i,
   input logic [`TART_LOG2_BITS-1:0]    block_log2_i,
   input logic                          soft_clr_i,
   input logic                          available_i
);

   int                          fail_cnt;       // Read by the bench top
   logic [7:0]                  seen_q;         // Samples taken in this block
   logic [`TART_LOG2_BITS-1:0]  log2_q;
   logic [`TART_LOG2_BITS-1:0]  log2_now;
   logic                        take;
   logic                        last_take;      // Final sample of a block enters

   assign take      = antenna_valid_i && enable_i;
   assign log2_now  = (seen_q == 8'd0) ? block_log2_i : log2_q;   // Size fixed at block start
   assign last_take = take && (seen_q == ((8'd1 << log2_now) - 8'd1));

   always_ff @(posedge b_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         seen_q <= 8'd0;
         log2_q <= '0;
      end else if (soft_clr_i) begin
         seen_q <= 8'd0;
      end else if (take) begin
         log2_q <= log2_now;
         seen_q <= last_take ? 8'd0 : seen_q + 8'd1;
      end
   end

   // ----------------------------------------
   // Wishbone handshake
   // ----------------------------------------
   ack_needs_strobe: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      ack_i |-> (cyc_i && stb_i))
      else begin fail_cnt++; $error("ack_o high without cyc_i and stb_i"); end

   ack_single: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      ack_i |=> !ack_i)
      else begin fail_cnt++; $error("ack_o high for two cycles in a row"); end

   ack_after_strobe: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      (cyc_i && $rose(stb_i)) |=> ack_i)
      else begin fail_cnt++; $error("ack_o missing one cycle after a new strobe"); end

   // ----------------------------------------
   // Block completion, overflow keeps newblock low
   // ----------------------------------------
   newblock_on_time: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      last_take |-> ##2 (newblock_i || available_i))
      else begin fail_cnt++; $error("newblock_o missing two cycles after last sample"); end

   newblock_has_cause: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      newblock_i |-> $past(last_take, 2))
      else begin fail_cnt++; $error("newblock_o without a finished block"); end

endmodule

bind tart_core tart_assert i_tart_assert (
   .b_clk(b_clk),                     .rst_n_i(rst_n_i),
   .cyc_i(cyc_i),                     .stb_i(stb_i),              .ack_i(ack_o),
   .antenna_valid_i(antenna_valid_i), .newblock_i(newblock_o),
   .enable_i(enable),                 .block_log2_i(block_log2),
   .soft_clr_i(soft_clr),             .available_i(available)
);

// File: bench/tb_clock.sv
`timescale 1ns/100ps

// Free-running bench clock, starts low
module tb_clock #(
   parameter real PERIOD_NS = 8.0
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   always #(PERIOD_NS / 2.0) clk_o = ~clk_o;   // 50 % duty

endmodule

// File: bench/tb_tart.sv
`timescale 1ns/100ps

`include "tart_consts.svh"

module tb_tart;

   // Samples and bus transfers of all tests, 8 ns cycle, margin of 4
   localparam int SAMPLE_COUNT = 80;
   localparam int XFER_COUNT   = 37;
   localparam int WATCHDOG_NS  = (SAMPLE_COUNT + XFER_COUNT) * 8 * 4;
   localparam logic [6:0] ADR_CTRL   = {`TART_CTRL_BLOCK, 3'd0};
   localparam logic [6:0] ADR_BLOCK  = ADR_CTRL + 7'd1;
   localparam logic [6:0] ADR_STATUS = ADR_CTRL + 7'd2;
   localparam logic [6:0] ADR_CSUM   = ADR_CTRL + 7'd3;
   localparam logic [6:0] ADR_UNMAP  = 7'h40;   // Neither block

   logic        b_clk;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [6:0]  adr;
   logic [7:0]  wdat;
   logic [7:0]  rdat;
   logic        ack;
   logic [3:0]  antenna;
   logic        ant_vld;
   logic        newblock;
   logic        model_en;     // Mirrors the enable bit
   int          model_vis [6];
   int          saved_vis [6];
   int          errors;
   int          checks;
   int          tests;
   int          err_mark;

   tb_clock i_tb_clock (.clk_o(b_clk));

   tart_core i_tart_core (
      .b_clk(b_clk),         .rst_n_i(rst_n),
      .cyc_i(cyc),           .stb_i(stb),       .we_i(we),
      .adr_i(adr),           .dat_i(wdat),      .dat_o(rdat),     .ack_o(ack),
      .antenna_i(antenna),   .antenna_valid_i(ant_vld),           .newblock_o(newblock)
   );

   function automatic int total_errors();
      return errors + i_tart_core.i_tart_assert.fail_cnt;
   endfunction

   task automatic check_val(input string sig, input int exp, input int act);
      checks++;
      assert (act == exp) else begin
         errors++;
         $display("ERROR at %0.1f ns: %s expected 0x%0h, got 0x%0h", $realtime, sig, exp, act);
      end
   endtask

   // ----------------------------------------
   // Wishbone classic master
   // ----------------------------------------
   task automatic bus_xfer(input logic wr, input logic [6:0] a, input logic [7:0] d,
                           output logic [7:0] q);
      int waited;
      waited = 0;
      @(posedge b_clk);
      #1;
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = wr;
      adr  = a;
      wdat = d;
      @(negedge b_clk);
      while (!ack && waited < 16) begin   // Slave never stalls
         @(negedge b_clk);
         waited++;
      end
      if (!ack) begin
         errors++;
         $display("No acknowledge for the access to address 0x%0h", a);
      end
      q = rdat;
      @(posedge b_clk);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_write(input logic [6:0] a, input logic [7:0] d);
      logic [7:0] unused;
      bus_xfer(1'b1, a, d, unused);
   endtask

   task automatic read_check(input logic [6:0] a, input int exp, input string sig);
      logic [7:0] q;
      bus_xfer(1'b0, a, 8'h00, q);
      check_val(sig, exp, q);
   endtask

   // ----------------------------------------
   // Reference model and sample stimulus
   // ----------------------------------------
   task automatic model_sample(input logic [3:0] ant);
      int p;
      p = 0;
      for (int a = 0; a < 4; a++) begin
         for (int b = a + 1; b < 4; b++) begin   // Pairs in index order
            if (ant[a] == ant[b]) model_vis[p]++;
            p++;
         end
      end
   endtask

   task automatic drive_samples(input int count, input logic valid);
      for (int i = 0; i < count; i++) begin
         @(posedge b_clk);
         #1;
         antenna = 4'($urandom);
         ant_vld = valid;
         if (valid && model_en) model_sample(antenna);
      end
      @(posedge b_clk);
      #1;
      ant_vld = 1'b0;
   endtask

   task automatic run_block(input int count);
      foreach (model_vis[p]) model_vis[p] = 0;
      drive_samples(count, 1'b1);
   endtask

   // Block lands two cycles after its last sample
   task automatic expect_block(input logic want);
      logic seen;
      seen = 1'b0;
      for (int i = 0; i < 8; i++) begin
         @(negedge b_clk);
         if (newblock) seen = 1'b1;
      end
      check_val("newblock_o", want, seen);
   endtask

   task automatic check_bank();
      int sum;
      sum = 0;
      for (int p = 0; p < 6; p++) begin
         read_check({`TART_VIS_BLOCK, 4'(p)}, model_vis[p], $sformatf("vis[%0d]", p));
         sum += model_vis[p];
      end
      read_check(ADR_CSUM, sum % 256, "checksum");
   endtask

   task automatic end_test(input string name);
      $display("%s: done, %0d errors", name, total_errors() - err_mark);
      err_mark = total_errors();
      tests++;
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

   initial begin : stimulus
      void'($urandom(32'h987a));
      rst_n    = 1'b0;
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      wdat     = '0;
      antenna  = '0;
      ant_vld  = 1'b0;
      model_en = 1'b0;
      repeat (16) @(posedge b_clk);
      #1;
      rst_n = 1'b1;

      bus_write(ADR_BLOCK, 8'hFD);
      read_check(ADR_BLOCK, 8'h05, "block_log2");   // Low 3 bits only
      read_check(ADR_UNMAP, 8'h00, "dat_o unmapped");
      read_check(ADR_STATUS, 8'h00, "status");
      end_test("Test 1 register access");

      bus_write(ADR_BLOCK, 8'd4);
      bus_write(ADR_CTRL, 8'h01);
      model_en = 1'b1;
      run_block(16);
      expect_block(1'b1);
      check_bank();                                  // Index 5 read frees the bank
      end_test("Test 2 block of 16 samples");

      drive_samples(16, 1'b0);
      expect_block(1'b0);
      read_check(ADR_STATUS, 8'h04, "status");
      bus_write(ADR_CTRL, 8'h00);
      model_en = 1'b0;
      drive_samples(16, 1'b1);
      expect_block(1'b0);
      read_check(ADR_STATUS, 8'h00, "status");       // Enable clear
      end_test("Test 3 no valid or no enable");

      bus_write(ADR_BLOCK, 8'd3);
      bus_write(ADR_CTRL, 8'h01);
      model_en = 1'b1;
      run_block(8);
      expect_block(1'b1);
      saved_vis = model_vis;
      run_block(8);                                  // Lost while the bank is full
      expect_block(1'b0);
      read_check(ADR_STATUS, 8'h07, "status");
      model_vis = saved_vis;
      check_bank();
      read_check(ADR_STATUS, 8'h06, "status");
      end_test("Test 4 overflow");

      run_block(8);
      expect_block(1'b1);
      read_check(ADR_STATUS, 8'h07, "status");
      bus_write(ADR_CTRL, 8'h81);                    // Soft reset with enable kept
      read_check(ADR_STATUS, 8'h04, "status");
      run_block(8);
      expect_block(1'b1);
      check_bank();
      end_test("Test 5 soft reset");

      $display("Summary: %0d tests, %0d checks, %0d bench errors, %0d assertion failures",
               tests, checks, errors, i_tart_core.i_tart_assert.fail_cnt);
      if (total_errors() == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: tart.f
+incdir+common
common/tart_bus_pkg.sv
common/tart_corr_pkg.sv
bus/wb_decoder.sv
bus/ctrl_regs.sv
correlator/corr_accumulate.sv
correlator/visibility_bank.sv
src/tart_core.sv
bench/tart_assert.sv
bench/tb_clock.sv
bench/tb_tart.sv

// File: Makefile
# Verilator flow for the tart correlator bench

VERILATOR ?= verilator
TOP       ?= tb_tart
DUT_TOP   ?= tart_core
FILELIST  ?= tart.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
